// ==== hdl/mem_stage_pkg.sv ====
// ####################
// widths, operation codes and lane codes of the memory stage
// big-endian with lane 3 holding bits 31..24 at address offset 0
// ####################
package mem_stage_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int LANES      = 4;
    localparam int ALUOP_W    = 8;
    localparam int LANE_SRC_W = 2;

    // any other code is a non-memory op
    localparam logic [ALUOP_W-1:0] OP_LB  = 8'b1110_0000;
    localparam logic [ALUOP_W-1:0] OP_LBU = 8'b1110_0100;
    localparam logic [ALUOP_W-1:0] OP_LH  = 8'b1110_0001;
    localparam logic [ALUOP_W-1:0] OP_LHU = 8'b1110_0101;
    localparam logic [ALUOP_W-1:0] OP_LW  = 8'b1110_0011;
    localparam logic [ALUOP_W-1:0] OP_LWL = 8'b1110_0010;
    localparam logic [ALUOP_W-1:0] OP_LWR = 8'b1110_0110;
    localparam logic [ALUOP_W-1:0] OP_LL  = 8'b1111_0000;
    localparam logic [ALUOP_W-1:0] OP_SB  = 8'b1110_1000;
    localparam logic [ALUOP_W-1:0] OP_SH  = 8'b1110_1001;
    localparam logic [ALUOP_W-1:0] OP_SW  = 8'b1110_1011;
    localparam logic [ALUOP_W-1:0] OP_SWL = 8'b1110_1010;
    localparam logic [ALUOP_W-1:0] OP_SWR = 8'b1110_1110;
    localparam logic [ALUOP_W-1:0] OP_SC  = 8'b1111_1000;

    // where a lane takes its load result byte from
    localparam logic [LANE_SRC_W-1:0] SRC_MEM  = 2'd0; // memory byte at load_idx
    localparam logic [LANE_SRC_W-1:0] SRC_REG  = 2'd1; // own byte of reg2
    localparam logic [LANE_SRC_W-1:0] SRC_ZERO = 2'd2;
    localparam logic [LANE_SRC_W-1:0] SRC_SIGN = 2'd3; // sign bit replicated

    // one data word, seen whole or as four byte lanes
    typedef union packed {
        logic [WORD_W-1:0]     word;
        logic [LANES-1:0][7:0] bytes; // bytes[3] is bits 31..24
    } mem_word_u;

endpackage

// ==== hdl/mem_access_decode.sv ====
// ####################
// combinational request and lane steering from aluop and address
// odd halfword loads give zero and odd halfword stores select no lane
// ####################
module mem_access_decode (
    input  logic [mem_stage_pkg::ALUOP_W-1:0]                   aluop_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]                    mem_addr_i,
    input  mem_stage_pkg::mem_word_u                            mem_rdata_i,
    input  logic                                                llbit_i,
    output logic [mem_stage_pkg::WORD_W-1:0]                    mem_addr_o,
    output logic                                                mem_we_o,
    output logic                                                mem_ce_o,
    output logic [mem_stage_pkg::LANES-1:0]                     mem_sel_o,
    output logic [mem_stage_pkg::LANES-1:0][1:0]                store_idx_o,
    output logic [mem_stage_pkg::LANES-1:0]                     store_zero_o,
    output logic [mem_stage_pkg::LANES-1:0][mem_stage_pkg::LANE_SRC_W-1:0] load_src_o,
    output logic [mem_stage_pkg::LANES-1:0][1:0]                load_idx_o,
    output logic                                                sign_o,
    output logic                                                load_op_o,
    output logic                                                sc_op_o,
    output logic                                                sc_ok_o,
    output logic                                                llbit_set_o,
    output logic                                                llbit_clr_o
);

    logic [1:0]                             off;
    logic [1:0]                             lane_at; // lane addressed by the offset
    logic [mem_stage_pkg::WORD_W-1:0]       addr_aligned;
    logic [mem_stage_pkg::LANE_SRC_W-1:0]   ext_src;

    assign off          = mem_addr_i[1:0];
    assign lane_at      = ~off;
    assign addr_aligned = {mem_addr_i[mem_stage_pkg::WORD_W-1:2], 2'b00};
    assign ext_src      = (aluop_i == mem_stage_pkg::OP_LB || aluop_i == mem_stage_pkg::OP_LH)
                          ? mem_stage_pkg::SRC_SIGN : mem_stage_pkg::SRC_ZERO;

    assign sign_o       = mem_rdata_i.bytes[lane_at][7]; // top bit of addressed byte or half
    assign sc_op_o      = (aluop_i == mem_stage_pkg::OP_SC);
    assign sc_ok_o      = sc_op_o & llbit_i;
    assign llbit_clr_o  = sc_ok_o;
    assign llbit_set_o  = (aluop_i == mem_stage_pkg::OP_LL);

    always_comb begin
        mem_ce_o   = 1'b0;
        mem_we_o   = 1'b0;
        mem_addr_o = '0;
        mem_sel_o  = 4'b1111;
        load_op_o  = 1'b0;
        for (int k = 0; k < mem_stage_pkg::LANES; k++) begin
            store_idx_o[k]  = 2'(k);
            store_zero_o[k] = 1'b1;
            load_src_o[k]   = mem_stage_pkg::SRC_ZERO;
            load_idx_o[k]   = 2'(k);
        end

        case (aluop_i)
            mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LBU: begin
                mem_ce_o        = 1'b1;
                mem_addr_o      = mem_addr_i;
                load_op_o       = 1'b1;
                mem_sel_o       = 4'b1000 >> off;
                load_src_o[0]   = mem_stage_pkg::SRC_MEM;
                load_idx_o[0]   = lane_at;
                load_src_o[3:1] = {3{ext_src}};
            end
            mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU: begin
                mem_ce_o   = 1'b1;
                mem_addr_o = mem_addr_i;
                load_op_o  = 1'b1;
                if (!off[0]) begin
                    mem_sel_o       = off[1] ? 4'b0011 : 4'b1100;
                    load_src_o[1:0] = {2{mem_stage_pkg::SRC_MEM}};
                    load_idx_o[1]   = lane_at;
                    load_idx_o[0]   = lane_at - 2'd1;
                    load_src_o[3:2] = {2{ext_src}};
                end
            end
            mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LL: begin
                mem_ce_o   = 1'b1;
                mem_addr_o = mem_addr_i;
                load_op_o  = 1'b1;
                load_src_o = {4{mem_stage_pkg::SRC_MEM}};
            end
            mem_stage_pkg::OP_LWL, mem_stage_pkg::OP_LWR: begin
                mem_ce_o   = 1'b1;
                mem_addr_o = addr_aligned;
                load_op_o  = 1'b1;
                for (int k = 0; k < mem_stage_pkg::LANES; k++) begin
                    load_src_o[k] = mem_stage_pkg::SRC_REG;
                    if (aluop_i == mem_stage_pkg::OP_LWL && k >= off) begin
                        load_src_o[k] = mem_stage_pkg::SRC_MEM;
                        load_idx_o[k] = 2'(k - off);
                    end else if (aluop_i == mem_stage_pkg::OP_LWR && k <= off) begin
                        load_src_o[k] = mem_stage_pkg::SRC_MEM;
                        load_idx_o[k] = 2'(k + 3 - off);
                    end
                end
            end
            mem_stage_pkg::OP_SB: begin
                mem_ce_o     = 1'b1;
                mem_we_o     = 1'b1;
                mem_addr_o   = mem_addr_i;
                mem_sel_o    = 4'b1000 >> off;
                store_idx_o  = '0; // low byte in every lane
                store_zero_o = '0;
            end
            mem_stage_pkg::OP_SH: begin
                mem_ce_o     = 1'b1;
                mem_we_o     = 1'b1;
                mem_addr_o   = mem_addr_i;
                mem_sel_o    = off[0] ? 4'b0000 : (off[1] ? 4'b0011 : 4'b1100);
                store_idx_o  = {2'd1, 2'd0, 2'd1, 2'd0};
                store_zero_o = '0;
            end
            mem_stage_pkg::OP_SW: begin
                mem_ce_o     = 1'b1;
                mem_we_o     = 1'b1;
                mem_addr_o   = mem_addr_i;
                store_zero_o = '0;
            end
            mem_stage_pkg::OP_SWL, mem_stage_pkg::OP_SWR: begin
                mem_ce_o   = 1'b1;
                mem_we_o   = 1'b1;
                mem_addr_o = addr_aligned;
                if (aluop_i == mem_stage_pkg::OP_SWL) begin
                    mem_sel_o = 4'b1111 >> off;
                end else begin
                    mem_sel_o = 4'b1111 << lane_at;
                end
                for (int k = 0; k < mem_stage_pkg::LANES; k++) begin
                    if (aluop_i == mem_stage_pkg::OP_SWL && k + off <= 3) begin
                        store_zero_o[k] = 1'b0;
                        store_idx_o[k]  = 2'(k + off);
                    end else if (aluop_i == mem_stage_pkg::OP_SWR && k >= lane_at) begin
                        store_zero_o[k] = 1'b0;
                        store_idx_o[k]  = 2'(k - lane_at);
                    end
                end
            end
            mem_stage_pkg::OP_SC: begin
                if (sc_ok_o) begin // link still held
                    mem_ce_o     = 1'b1;
                    mem_we_o     = 1'b1;
                    mem_addr_o   = mem_addr_i;
                    store_zero_o = '0;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hdl/mem_byte_lane.sv ====
// ####################
// one byte lane where LANE 3 is the most significant
// ####################
module mem_byte_lane #(
    parameter int LANE = 0
) (
    input  mem_stage_pkg::mem_word_u                reg2_i,
    input  mem_stage_pkg::mem_word_u                mem_rdata_i,
    input  logic [1:0]                              store_idx_i,
    input  logic                                    store_zero_i,
    input  logic [mem_stage_pkg::LANE_SRC_W-1:0]    load_src_i,
    input  logic [1:0]                              load_idx_i,
    input  logic                                    sign_i,
    output logic [7:0]                              store_byte_o,
    output logic [7:0]                              load_byte_o
);

    logic [7:0] reg2_byte;

    assign reg2_byte = reg2_i.bytes[store_idx_i];

    // freed lanes of SWL/SWR and all non-store ops drive zero
    assign store_byte_o = store_zero_i ? 8'h00 : reg2_byte;

    always_comb begin
        case (load_src_i)
            mem_stage_pkg::SRC_MEM: begin
                load_byte_o = mem_rdata_i.bytes[load_idx_i];
            end
            mem_stage_pkg::SRC_REG: begin
                load_byte_o = reg2_i.bytes[LANE]; // unmerged part of LWL/LWR
            end
            mem_stage_pkg::SRC_ZERO: begin
                load_byte_o = 8'h00;
            end
            default: begin
                load_byte_o = {8{sign_i}};
            end
        endcase
    end

endmodule

// ==== hdl/mem_writeback_reg.sv ====
// ####################
// MEM/WB register and LL bit that update on the same clk edge
// ####################
module mem_writeback_reg (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                                wreg_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]    wdata_i,
    input  logic                                load_op_i,
    input  logic                                sc_op_i,
    input  logic                                sc_ok_i,
    input  mem_stage_pkg::mem_word_u            load_word_i,
    input  logic                                llbit_set_i,
    input  logic                                llbit_clr_i,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0] wb_wd_o,
    output logic                                wb_wreg_o,
    output logic [mem_stage_pkg::WORD_W-1:0]    wb_wdata_o,
    output logic                                llbit_o
);

    logic [mem_stage_pkg::WORD_W-1:0] wdata_next;

    always_comb begin
        if (sc_op_i) begin
            wdata_next = mem_stage_pkg::WORD_W'(sc_ok_i); // 1 on success, 0 otherwise
        end else if (load_op_i) begin
            wdata_next = load_word_i.word;
        end else begin
            wdata_next = wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_wd_o    <= '0;
            wb_wreg_o  <= 1'b0;
            wb_wdata_o <= '0;
        end else begin
            wb_wd_o    <= wd_i;
            wb_wreg_o  <= wreg_i;
            wb_wdata_o <= wdata_next;
        end
    end

    // set by LL, cleared by a successful SC
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_o <= 1'b0;
        end else if (llbit_set_i) begin
            llbit_o <= 1'b1;
        end else if (llbit_clr_i) begin
            llbit_o <= 1'b0;
        end
    end

endmodule

// ==== hdl/mem_stage_top.sv ====
// ####################
// memory access stage with the request out in the same cycle
// writeback appears one clk later and there is no back-pressure
// ####################
module mem_stage_top (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic [mem_stage_pkg::REG_ADDR_W-1:0]    wd_i,
    input  logic                                    wreg_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]        wdata_i,
    input  logic [mem_stage_pkg::ALUOP_W-1:0]       aluop_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]        mem_addr_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]        reg2_i,
    input  logic [mem_stage_pkg::WORD_W-1:0]        mem_rdata_i,
    output logic [mem_stage_pkg::WORD_W-1:0]        mem_addr_o,
    output logic                                    mem_we_o,
    output logic [mem_stage_pkg::LANES-1:0]         mem_sel_o,
    output logic [mem_stage_pkg::WORD_W-1:0]        mem_wdata_o,
    output logic                                    mem_ce_o,
    output logic [mem_stage_pkg::REG_ADDR_W-1:0]    wb_wd_o,
    output logic                                    wb_wreg_o,
    output logic [mem_stage_pkg::WORD_W-1:0]        wb_wdata_o
);

    mem_stage_pkg::mem_word_u                                       reg2_u;
    mem_stage_pkg::mem_word_u                                       rdata_u;
    wire mem_stage_pkg::mem_word_u                                  store_u;
    wire mem_stage_pkg::mem_word_u                                  load_u;
    logic [mem_stage_pkg::LANES-1:0][1:0]                           store_idx;
    logic [mem_stage_pkg::LANES-1:0]                                store_zero;
    logic [mem_stage_pkg::LANES-1:0][mem_stage_pkg::LANE_SRC_W-1:0] load_src;
    logic [mem_stage_pkg::LANES-1:0][1:0]                           load_idx;
    logic                                                           sign;
    logic                                                           load_op;
    logic                                                           sc_op;
    logic                                                           sc_ok;
    logic                                                           llbit_set;
    logic                                                           llbit_clr;
    logic                                                           llbit;

    assign reg2_u.word  = reg2_i;
    assign rdata_u.word = mem_rdata_i;
    assign mem_wdata_o  = store_u.word;

    mem_access_decode u_decode (
        .aluop_i      (aluop_i),
        .mem_addr_i   (mem_addr_i),
        .mem_rdata_i  (rdata_u),
        .llbit_i      (llbit),
        .mem_addr_o   (mem_addr_o),
        .mem_we_o     (mem_we_o),
        .mem_ce_o     (mem_ce_o),
        .mem_sel_o    (mem_sel_o),
        .store_idx_o  (store_idx),
        .store_zero_o (store_zero),
        .load_src_o   (load_src),
        .load_idx_o   (load_idx),
        .sign_o       (sign),
        .load_op_o    (load_op),
        .sc_op_o      (sc_op),
        .sc_ok_o      (sc_ok),
        .llbit_set_o  (llbit_set),
        .llbit_clr_o  (llbit_clr)
    );

    for (genvar k = 0; k < mem_stage_pkg::LANES; k++) begin : g_lane
        mem_byte_lane #(
            .LANE (k)
        ) u_lane (
            .reg2_i       (reg2_u),
            .mem_rdata_i  (rdata_u),
            .store_idx_i  (store_idx[k]),
            .store_zero_i (store_zero[k]),
            .load_src_i   (load_src[k]),
            .load_idx_i   (load_idx[k]),
            .sign_i       (sign),
            .store_byte_o (store_u.bytes[k]),
            .load_byte_o  (load_u.bytes[k])
        );
    end

    mem_writeback_reg u_wb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .wdata_i     (wdata_i),
        .load_op_i   (load_op),
        .sc_op_i     (sc_op),
        .sc_ok_i     (sc_ok),
        .load_word_i (load_u),
        .llbit_set_i (llbit_set),
        .llbit_clr_i (llbit_clr),
        .wb_wd_o     (wb_wd_o),
        .wb_wreg_o   (wb_wreg_o),
        .wb_wdata_o  (wb_wdata_o),
        .llbit_o     (llbit)
    );

endmodule

// ==== testbench/tb_mem_stage_model.svh ====
// ####################
// expected request and writeback data of one instruction
// rword is the aligned memory word before any store of this cycle
// ####################
`ifndef TB_MEM_STAGE_MODEL_SVH
`define TB_MEM_STAGE_MODEL_SVH

task automatic predict_request(
    input  logic [mem_stage_pkg::ALUOP_W-1:0] op,
    input  logic [mem_stage_pkg::WORD_W-1:0]  addr,
    input  logic [mem_stage_pkg::WORD_W-1:0]  reg2,
    input  logic                              llbit,
    output logic [mem_stage_pkg::WORD_W-1:0]  addr_o,
    output logic                              we,
    output logic                              ce,
    output logic [mem_stage_pkg::LANES-1:0]   sel,
    output logic [mem_stage_pkg::WORD_W-1:0]  wdata
);
    logic [1:0] off;
    off    = addr[1:0];
    addr_o = '0;
    we     = 1'b0;
    ce     = 1'b0;
    sel    = 4'b1111;
    wdata  = '0;
    case (op)
        mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LBU: begin
            ce     = 1'b1;
            addr_o = addr;
            sel    = 4'b1000 >> off; // offset 0 is the top lane
        end
        mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU: begin
            ce     = 1'b1;
            addr_o = addr;
            if (!off[0]) begin
                sel = (off == 2'd0) ? 4'b1100 : 4'b0011;
            end
        end
        mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LL: begin
            ce     = 1'b1;
            addr_o = addr;
        end
        mem_stage_pkg::OP_LWL, mem_stage_pkg::OP_LWR: begin
            ce     = 1'b1;
            addr_o = addr & ~32'd3;
        end
        mem_stage_pkg::OP_SB: begin
            ce     = 1'b1;
            we     = 1'b1;
            addr_o = addr;
            sel    = 4'b1000 >> off;
            wdata  = {4{reg2[7:0]}};
        end
        mem_stage_pkg::OP_SH: begin
            ce     = 1'b1;
            we     = 1'b1;
            addr_o = addr;
            sel    = off[0] ? 4'b0000 : ((off == 2'd0) ? 4'b1100 : 4'b0011);
            wdata  = {2{reg2[15:0]}};
        end
        mem_stage_pkg::OP_SW: begin
            ce     = 1'b1;
            we     = 1'b1;
            addr_o = addr;
            wdata  = reg2;
        end
        mem_stage_pkg::OP_SWL: begin
            ce     = 1'b1;
            we     = 1'b1;
            addr_o = addr & ~32'd3;
            sel    = 4'b1111 >> off;
            wdata  = reg2 >> (8 * off); // top bytes moved down
        end
        mem_stage_pkg::OP_SWR: begin
            ce     = 1'b1;
            we     = 1'b1;
            addr_o = addr & ~32'd3;
            sel    = 4'b1111 << (3 - off);
            wdata  = reg2 << (8 * (3 - off));
        end
        mem_stage_pkg::OP_SC: begin
            if (llbit) begin
                ce     = 1'b1;
                we     = 1'b1;
                addr_o = addr;
                wdata  = reg2;
            end
        end
        default: begin
        end
    endcase
endtask

function automatic logic [mem_stage_pkg::WORD_W-1:0] predict_result(
    input logic [mem_stage_pkg::ALUOP_W-1:0] op,
    input logic [mem_stage_pkg::WORD_W-1:0]  addr,
    input logic [mem_stage_pkg::WORD_W-1:0]  reg2,
    input logic [mem_stage_pkg::WORD_W-1:0]  wdata,
    input logic [mem_stage_pkg::WORD_W-1:0]  rword,
    input logic                              llbit
);
    logic [1:0]  off;
    logic [7:0]  b;
    logic [15:0] h;
    off = addr[1:0];
    b   = 8'(rword >> (8 * (3 - off)));
    h   = off[1] ? rword[15:0] : rword[31:16];
    case (op)
        mem_stage_pkg::OP_LB:  return {{24{b[7]}}, b};
        mem_stage_pkg::OP_LBU: return {24'h0, b};
        mem_stage_pkg::OP_LH:  return off[0] ? 32'h0 : {{16{h[15]}}, h};
        mem_stage_pkg::OP_LHU: return off[0] ? 32'h0 : {16'h0, h};
        mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LL: return rword;
        mem_stage_pkg::OP_LWL:
            return (rword << (8 * off)) | (reg2 & ~(32'hffff_ffff << (8 * off)));
        mem_stage_pkg::OP_LWR:
            return (rword >> (8 * (3 - off))) | (reg2 & ~(32'hffff_ffff >> (8 * (3 - off))));
        mem_stage_pkg::OP_SC:  return {31'h0, llbit};
        default:               return wdata; // stores and non-memory ops
    endcase
endfunction

`endif

// ==== testbench/tb_mem_stage.sv ====
// ####################
// directed and random ops against a 64-byte memory
// upper address bits stay zero and the first error stops the run
// ####################
module tb_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    logic                                    clk;
    logic                                    rst_n_i;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]    wd_i;
    logic                                    wreg_i;
    logic [mem_stage_pkg::WORD_W-1:0]        wdata_i;
    logic [mem_stage_pkg::ALUOP_W-1:0]       aluop_i;
    logic [mem_stage_pkg::WORD_W-1:0]        mem_addr_i;
    logic [mem_stage_pkg::WORD_W-1:0]        reg2_i;
    logic [mem_stage_pkg::WORD_W-1:0]        mem_rdata_i;
    logic [mem_stage_pkg::WORD_W-1:0]        mem_addr_o;
    logic                                    mem_we_o;
    logic [mem_stage_pkg::LANES-1:0]         mem_sel_o;
    logic [mem_stage_pkg::WORD_W-1:0]        mem_wdata_o;
    logic                                    mem_ce_o;
    logic [mem_stage_pkg::REG_ADDR_W-1:0]    wb_wd_o;
    logic                                    wb_wreg_o;
    logic [mem_stage_pkg::WORD_W-1:0]        wb_wdata_o;

    logic [7:0]                              ram [0:63];
    int                                      ram_writes;
    logic                                    ref_llbit;
    logic [mem_stage_pkg::ALUOP_W-1:0]       mem_ops [0:13];

    `include "tb_mem_stage_model.svh"

    mem_stage_top dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .wdata_i     (wdata_i),
        .aluop_i     (aluop_i),
        .mem_addr_i  (mem_addr_i),
        .reg2_i      (reg2_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .mem_we_o    (mem_we_o),
        .mem_sel_o   (mem_sel_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ce_o    (mem_ce_o),
        .wb_wd_o     (wb_wd_o),
        .wb_wreg_o   (wb_wreg_o),
        .wb_wdata_o  (wb_wdata_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return {ram[{addr[5:2], 2'd0}], ram[{addr[5:2], 2'd1}],
                ram[{addr[5:2], 2'd2}], ram[{addr[5:2], 2'd3}]};
    endfunction

    // read data follows the request address in the same cycle
    always @(mem_addr_o or ram_writes) begin
        mem_rdata_i = read_word(mem_addr_o);
    end

    task automatic write_ram(input logic [31:0] addr, input logic [3:0] sel,
                             input logic [31:0] data);
        for (int k = 0; k < 4; k++) begin
            if (sel[k]) begin
                ram[{addr[5:2], 2'(3 - k)}] <= data[8*k +: 8]; // lane k is offset 3-k
            end
        end
        ram_writes <= ram_writes + 1;
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_on_error($sformatf("Fail %s got 0x%h exp 0x%h (aluop 0x%h addr 0x%h)",
                                name, got, exp, aluop_i, mem_addr_i));
    endtask

    task automatic check_request(input logic [mem_stage_pkg::WORD_W-1:0] exp_addr,
                                 input logic                             exp_we,
                                 input logic                             exp_ce,
                                 input logic [mem_stage_pkg::LANES-1:0]  exp_sel,
                                 input logic [mem_stage_pkg::WORD_W-1:0] exp_wdata);
        if (mem_ce_o !== exp_ce) report_mismatch("mem_ce_o", mem_ce_o, exp_ce);
        if (mem_we_o !== exp_we) report_mismatch("mem_we_o", mem_we_o, exp_we);
        if (mem_addr_o !== exp_addr) report_mismatch("mem_addr_o", mem_addr_o, exp_addr);
        if (mem_sel_o !== exp_sel) report_mismatch("mem_sel_o", mem_sel_o, exp_sel);
        if (mem_wdata_o !== exp_wdata) report_mismatch("mem_wdata_o", mem_wdata_o, exp_wdata);
    endtask

    task automatic check_wb(input logic [mem_stage_pkg::REG_ADDR_W-1:0] exp_wd,
                            input logic                                 exp_wreg,
                            input logic [mem_stage_pkg::WORD_W-1:0]     exp_wdata);
        if (wb_wd_o !== exp_wd) report_mismatch("wb_wd_o", wb_wd_o, exp_wd);
        if (wb_wreg_o !== exp_wreg) report_mismatch("wb_wreg_o", wb_wreg_o, exp_wreg);
        if (wb_wdata_o !== exp_wdata) report_mismatch("wb_wdata_o", wb_wdata_o, exp_wdata);
    endtask

    // drive one instruction, check its request and then its writeback
    task automatic run_op(input logic [mem_stage_pkg::ALUOP_W-1:0] op,
                          input logic [mem_stage_pkg::WORD_W-1:0]  addr);
        logic [mem_stage_pkg::WORD_W-1:0]     exp_addr;
        logic                                 exp_we;
        logic                                 exp_ce;
        logic [mem_stage_pkg::LANES-1:0]      exp_sel;
        logic [mem_stage_pkg::WORD_W-1:0]     exp_wdata;
        logic [mem_stage_pkg::WORD_W-1:0]     exp_result;
        logic [mem_stage_pkg::REG_ADDR_W-1:0] exp_wd;
        logic                                 exp_wreg;
        @(negedge clk);
        aluop_i    = op;
        mem_addr_i = addr;
        reg2_i     = $urandom;
        wdata_i    = $urandom;
        wd_i       = $urandom_range(31, 0);
        wreg_i     = $urandom_range(1, 0);
        exp_wd     = wd_i;
        exp_wreg   = wreg_i;
        #2;
        predict_request(op, addr, reg2_i, ref_llbit, exp_addr, exp_we, exp_ce, exp_sel,
                        exp_wdata);
        check_request(exp_addr, exp_we, exp_ce, exp_sel, exp_wdata);
        exp_result = predict_result(op, addr, reg2_i, wdata_i, read_word(exp_addr), ref_llbit);
        @(posedge clk);
        if (exp_ce && exp_we) begin
            write_ram(exp_addr, exp_sel, exp_wdata);
        end
        if (op == mem_stage_pkg::OP_LL) begin
            ref_llbit = 1'b1;
        end else if (op == mem_stage_pkg::OP_SC) begin
            ref_llbit = 1'b0;
        end
        #1;
        check_wb(exp_wd, exp_wreg, exp_result);
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(32'he5e3_1b7d));
        clk         = 1'b0;
        rst_n_i     = 1'b0;
        wd_i        = '1; // busy inputs that reset must hold off
        wreg_i      = 1'b1;
        wdata_i     = '1;
        aluop_i     = mem_stage_pkg::OP_LL;
        mem_addr_i  = '0;
        reg2_i      = '0;
        mem_rdata_i = '0;
        ref_llbit   = 1'b0;
        for (int a = 0; a < 64; a++) begin
            ram[a] = 8'(a * 37 + 27);
        end
        ram_writes = 1;
        mem_ops = '{mem_stage_pkg::OP_LB, mem_stage_pkg::OP_LBU, mem_stage_pkg::OP_LH,
                    mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_LW, mem_stage_pkg::OP_LWL,
                    mem_stage_pkg::OP_LWR, mem_stage_pkg::OP_LL, mem_stage_pkg::OP_SB,
                    mem_stage_pkg::OP_SH, mem_stage_pkg::OP_SW, mem_stage_pkg::OP_SWL,
                    mem_stage_pkg::OP_SWR, mem_stage_pkg::OP_SC};

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        wait_cycles = 0;
        while (wb_wreg_o !== 1'b0 || wb_wd_o !== '0 || wb_wdata_o !== '0) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 4) begin
                stop_on_error("writeback register did not clear while reset was held");
            end
        end
        @(negedge clk);
        rst_n_i = 1'b1;
        aluop_i = '0;

        run_op(mem_stage_pkg::OP_SC, 32'h10); // no link yet
        run_op(mem_stage_pkg::OP_LL, 32'h24);
        run_op(mem_stage_pkg::OP_SC, 32'h24);
        run_op(mem_stage_pkg::OP_SC, 32'h24); // link already used

        for (int i = 0; i < 14; i++) begin
            for (int off = 0; off < 4; off++) begin
                run_op(mem_ops[i], {26'h0, 4'($urandom), 2'(off)});
            end
        end

        for (int n = 0; n < 4000; n++) begin
            if ($urandom_range(3, 0) == 0) begin
                run_op(8'($urandom), 32'($urandom_range(63, 0)));
            end else begin
                run_op(mem_ops[$urandom_range(13, 0)], 32'($urandom_range(63, 0)));
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== mem_stage.f ====
+incdir+testbench
hdl/mem_stage_pkg.sv
hdl/mem_access_decode.sv
hdl/mem_byte_lane.sv
hdl/mem_writeback_reg.sv
hdl/mem_stage_top.sv
testbench/tb_mem_stage.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - hdl/mem_stage_pkg.sv
  - hdl/mem_access_decode.sv
  - hdl/mem_byte_lane.sv
  - hdl/mem_writeback_reg.sv
  - hdl/mem_stage_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_mem_stage.sv
